/* alu_cluster.sv */
module alu_cluster (
    input  logic  clk,
    input  logic  reset_i,
    exec_if.sink  exec_i [core_pkg::NUM_LANES],    // One issue port per lane
    cdb_if.source cdb_o
);
    import core_pkg::*;
    import isa_pkg::*;

    // Single cycle integer ALU
    function automatic word_t alu(alu_op_t op, word_t a, word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[SHAMT_W-1:0];
            SRL:     return a >> b[SHAMT_W-1:0];
            SLT:     return word_t'($signed(a) < $signed(b));
            default: return '0;
        endcase
    endfunction

    // ======================================================================
    // Per lane compute
    // ======================================================================

    logic      [NUM_LANES-1:0] ex_valid;
    slot_idx_t [NUM_LANES-1:0] ex_dest;
    word_t     [NUM_LANES-1:0] ex_result;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_alu
        assign ex_valid[g]  = exec_i[g].valid;
        assign ex_dest[g]   = exec_i[g].dest;
        assign ex_result[g] = alu(exec_i[g].op, exec_i[g].a, exec_i[g].b);
    end

    // Broadcast one cycle after issue
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cdb_o.valid <= '0;
        end else begin
            cdb_o.valid <= ex_valid;
        end
    end

    // Slot and data only matter under valid
    always_ff @(posedge clk) begin
        cdb_o.slot <= ex_dest;
        cdb_o.data <= ex_result;
    end

endmodule

/* core_pkg.sv */
package core_pkg;

    // ======================================================================
    // Core sizes
    // ======================================================================

    localparam int XLEN      = 32;             // Data path width
    localparam int NUM_LANES = 3;              // Dispatch lanes, one ALU each
    localparam int ARCH_REGS = 32;             // Architectural registers
    localparam int NUM_SLOTS = 32;             // Result table entries
    localparam int RS_DEPTH  = 4;              // Entries per station

    // Derived field widths
    localparam int REG_W    = $clog2(ARCH_REGS);
    localparam int SLOT_W   = $clog2(NUM_SLOTS);
    localparam int SRC_W    = SLOT_W + 1;      // Top bit picks the result table
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    // ======================================================================
    // Data path types
    // ======================================================================

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [SLOT_W-1:0] slot_idx_t;     // Also the wakeup tag on the CDB

    // Source operand address
    // Bit SRC_W-1 set means result slot, else architectural register
    typedef logic [SRC_W-1:0]  src_addr_t;

endpackage

/* dispatch_ifs.sv */
// Operand fetch to reservation station, one per lane
interface rs_entry_if;
    import core_pkg::*;
    import isa_pkg::*;

    logic      valid;                          // Dispatch request
    alu_op_t   op;
    word_t     a_val;
    logic      a_rdy;                          // Operand A value is final
    slot_idx_t a_tag;                          // Producer slot while not ready
    word_t     b_val;
    logic      b_rdy;
    slot_idx_t b_tag;
    slot_idx_t dest;                           // Result slot of this instruction
    logic      ready;                          // Station not full

    modport source (output valid, op, a_val, a_rdy, a_tag, b_val, b_rdy, b_tag, dest,
                    input  ready);
    modport sink   (input  valid, op, a_val, a_rdy, a_tag, b_val, b_rdy, b_tag, dest,
                    output ready);
endinterface

// Station issue to ALU, no back-pressure
interface exec_if;
    import core_pkg::*;
    import isa_pkg::*;

    logic      valid;
    alu_op_t   op;
    word_t     a;
    word_t     b;
    slot_idx_t dest;

    modport source (output valid, op, a, b, dest);
    modport sink   (input  valid, op, a, b, dest);
endinterface

// Common data bus, one group per lane
interface cdb_if;
    import core_pkg::*;

    logic      [NUM_LANES-1:0] valid;          // One cycle strobe per result
    slot_idx_t [NUM_LANES-1:0] slot;           // Slot written, doubles as tag
    word_t     [NUM_LANES-1:0] data;

    modport source   (output valid, slot, data);
    modport listener (input  valid, slot, data);
endinterface

/* dispatch_stage.sv */
module dispatch_stage (
    input  logic                                           clk,
    input  logic                                           reset_i,

    // Dispatch, packed per lane
    input  logic                [core_pkg::NUM_LANES-1:0] disp_valid_i,
    output logic                [core_pkg::NUM_LANES-1:0] disp_ready_o,
    input  isa_pkg::alu_op_t    [core_pkg::NUM_LANES-1:0] disp_op_i,
    input  core_pkg::src_addr_t [core_pkg::NUM_LANES-1:0] disp_src_a_i,
    input  core_pkg::src_addr_t [core_pkg::NUM_LANES-1:0] disp_src_b_i,
    input  logic                [core_pkg::NUM_LANES-1:0] disp_use_imm_i,
    input  core_pkg::word_t     [core_pkg::NUM_LANES-1:0] disp_imm_i,
    input  core_pkg::slot_idx_t [core_pkg::NUM_LANES-1:0] disp_dest_i,

    // Retire
    input  logic                                           retire_valid_i,
    input  core_pkg::reg_idx_t                             retire_reg_i,
    input  core_pkg::slot_idx_t                            retire_slot_i,

    // Result broadcast
    output logic                [core_pkg::NUM_LANES-1:0] cdb_valid_o,
    output core_pkg::slot_idx_t [core_pkg::NUM_LANES-1:0] cdb_slot_o,
    output core_pkg::word_t     [core_pkg::NUM_LANES-1:0] cdb_data_o
);
    import core_pkg::*;

    // ======================================================================
    // Internal buses
    // ======================================================================

    rs_entry_if entry_bus [NUM_LANES] ();      // Fetch to stations
    exec_if     exec_bus  [NUM_LANES] ();      // Stations to ALUs
    cdb_if      cdb_bus ();                    // ALUs to everyone

    operand_fetch u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .disp_valid_i   (disp_valid_i),
        .disp_ready_o   (disp_ready_o),
        .disp_op_i      (disp_op_i),
        .disp_src_a_i   (disp_src_a_i),
        .disp_src_b_i   (disp_src_b_i),
        .disp_use_imm_i (disp_use_imm_i),
        .disp_imm_i     (disp_imm_i),
        .disp_dest_i    (disp_dest_i),
        .retire_valid_i (retire_valid_i),
        .retire_reg_i   (retire_reg_i),
        .retire_slot_i  (retire_slot_i),
        .rs_o           (entry_bus),
        .cdb_i          (cdb_bus)
    );

    // One station per lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_rs
        reservation_station u_rs (
            .clk     (clk),
            .reset_i (reset_i),
            .entry_i (entry_bus[g]),
            .cdb_i   (cdb_bus),
            .exec_o  (exec_bus[g])
        );
    end

    alu_cluster u_alu (
        .clk     (clk),
        .reset_i (reset_i),
        .exec_i  (exec_bus),
        .cdb_o   (cdb_bus)
    );

    assign cdb_valid_o = cdb_bus.valid;
    assign cdb_slot_o  = cdb_bus.slot;
    assign cdb_data_o  = cdb_bus.data;

endmodule

/* dispatch_stage_chk.sv */
module dispatch_stage_chk (
    input  logic                                           clk_i,
    input  logic                                           reset_i,
    input  logic                [core_pkg::NUM_LANES-1:0] disp_valid_i,
    input  logic                [core_pkg::NUM_LANES-1:0] disp_ready_i,
    input  logic                [core_pkg::NUM_LANES-1:0] cdb_valid_i,
    input  core_pkg::slot_idx_t [core_pkg::NUM_LANES-1:0] cdb_slot_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    logic [NUM_LANES-1:0] accepted_seen;      // Lane took something since reset
    int                   assert_errs = 0;    // Failed assertions so far

    always_ff @(posedge clk_i) begin
        if (reset_i) accepted_seen <= '0;
        else         accepted_seen <= accepted_seen | (disp_valid_i & disp_ready_i);
    end

    // Two valid lanes naming the same slot
    function automatic logic slot_clash(logic [NUM_LANES-1:0] v,
                                        slot_idx_t [NUM_LANES-1:0] s);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int j = i + 1; j < NUM_LANES; j++) begin
                if (v[i] && v[j] && (s[i] == s[j])) hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ======================================================================
    // Properties
    // ======================================================================

    a_quiet_after_reset: assert property (@(posedge clk_i) reset_i |=> (cdb_valid_i == '0))
        else begin
            $error("CDB strobe in the cycle after reset");
            assert_errs++;
        end

    a_no_slot_clash: assert property (@(posedge clk_i) disable iff (reset_i)
                                      !slot_clash(cdb_valid_i, cdb_slot_i))
        else begin
            $error("Two CDB lanes carry the same slot");
            assert_errs++;
        end

    a_ready_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
                                        ((~accepted_seen & ~disp_ready_i) == '0))
        else begin
            $error("Ready low on a lane whose station is still empty");
            assert_errs++;
        end

endmodule

bind dispatch_stage dispatch_stage_chk u_chk (
    .clk_i        (clk),
    .reset_i      (reset_i),
    .disp_valid_i (disp_valid_i),
    .disp_ready_i (disp_ready_o),
    .cdb_valid_i  (cdb_valid_o),
    .cdb_slot_i   (cdb_slot_o)
);

/* isa_pkg.sv */
package isa_pkg;

    // ======================================================================
    // ALU operation encoding
    // ======================================================================

    localparam int ALU_OP_W = 3;
    localparam int SHAMT_W  = 5;               // Shift amount from low bits of B

    typedef enum logic [ALU_OP_W-1:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,                            // Logical, zero fill
        SLT = 3'd7                             // Signed compare, result 0 or 1
    } alu_op_t;

endpackage

/* operand_fetch.sv */
module operand_fetch (
    input  logic                                         clk,
    input  logic                                         reset_i,

    // Dispatch request, packed per lane
    input  logic              [core_pkg::NUM_LANES-1:0] disp_valid_i,
    output logic              [core_pkg::NUM_LANES-1:0] disp_ready_o,
    input  isa_pkg::alu_op_t  [core_pkg::NUM_LANES-1:0] disp_op_i,
    input  core_pkg::src_addr_t [core_pkg::NUM_LANES-1:0] disp_src_a_i,
    input  core_pkg::src_addr_t [core_pkg::NUM_LANES-1:0] disp_src_b_i,
    input  logic              [core_pkg::NUM_LANES-1:0] disp_use_imm_i,
    input  core_pkg::word_t   [core_pkg::NUM_LANES-1:0] disp_imm_i,
    input  core_pkg::slot_idx_t [core_pkg::NUM_LANES-1:0] disp_dest_i,

    // Retire port, slot value into register
    input  logic                                         retire_valid_i,
    input  core_pkg::reg_idx_t                           retire_reg_i,
    input  core_pkg::slot_idx_t                          retire_slot_i,

    rs_entry_if.source                                   rs_o [core_pkg::NUM_LANES],
    cdb_if.listener                                      cdb_i
);
    import core_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================

    word_t                 arch_rf  [ARCH_REGS];   // Architectural registers
    word_t                 slot_val [NUM_SLOTS];   // Result table values
    logic  [NUM_SLOTS-1:0] slot_filled;            // Slot holds a final value

    // Local view of the result buses
    logic      [NUM_LANES-1:0] cdb_valid;
    slot_idx_t [NUM_LANES-1:0] cdb_slot;
    word_t     [NUM_LANES-1:0] cdb_data;

    assign cdb_valid = cdb_i.valid;
    assign cdb_slot  = cdb_i.slot;
    assign cdb_data  = cdb_i.data;

    // Resolve one source into value and ready flag
    function automatic void lookup(
        input  src_addr_t src,
        output word_t     val,
        output logic      rdy
    );
        slot_idx_t slot;
        slot = src[SLOT_W-1:0];
        if (!src[SRC_W-1]) begin
            val = arch_rf[src[REG_W-1:0]];     // r0 is never written
            rdy = 1'b1;
        end else begin
            val = slot_val[slot];
            rdy = slot_filled[slot];
            // Same cycle bypass from any CDB lane
            for (int l = 0; l < NUM_LANES; l++) begin
                if (cdb_valid[l] && (cdb_slot[l] == slot)) begin
                    val = cdb_data[l];
                    rdy = 1'b1;
                end
            end
        end
    endfunction

    // ======================================================================
    // Per lane source lookup, all combinational
    // ======================================================================

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        word_t a_val;
        word_t b_val;
        logic  a_rdy;
        logic  b_rdy;

        always_comb begin
            lookup(disp_src_a_i[g], a_val, a_rdy);
            lookup(disp_src_b_i[g], b_val, b_rdy);
        end

        assign rs_o[g].valid = disp_valid_i[g];
        assign rs_o[g].op    = disp_op_i[g];
        assign rs_o[g].a_val = a_val;
        assign rs_o[g].a_rdy = a_rdy;
        assign rs_o[g].a_tag = disp_src_a_i[g][SLOT_W-1:0];
        // Immediate replaces B and is always ready
        assign rs_o[g].b_val = disp_use_imm_i[g] ? disp_imm_i[g] : b_val;
        assign rs_o[g].b_rdy = disp_use_imm_i[g] | b_rdy;
        assign rs_o[g].b_tag = disp_src_b_i[g][SLOT_W-1:0];
        assign rs_o[g].dest  = disp_dest_i[g];

        assign disp_ready_o[g] = rs_o[g].ready;    // Station has a free entry
    end

    // ======================================================================
    // Filled bits and register file
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_filled <= '0;
            for (int r = 0; r < ARCH_REGS; r++) begin
                arch_rf[r] <= '0;
            end
        end else begin
            // Accepted dispatch puts its dest slot in flight
            for (int l = 0; l < NUM_LANES; l++) begin
                if (disp_valid_i[l] && disp_ready_o[l]) begin
                    slot_filled[disp_dest_i[l]] <= 1'b0;
                end
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (cdb_valid[l]) begin
                    slot_filled[cdb_slot[l]] <= 1'b1;
                end
            end
            // Register 0 stays hard zero
            if (retire_valid_i && (retire_reg_i != '0)) begin
                arch_rf[retire_reg_i] <= slot_val[retire_slot_i];
            end
        end
    end

    // Result values, written straight from the CDB
    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (cdb_valid[l]) begin
                slot_val[cdb_slot[l]] <= cdb_data[l];
            end
        end
    end

endmodule

/* reservation_station.sv */
module reservation_station (
    input  logic      clk,
    input  logic      reset_i,
    rs_entry_if.sink  entry_i,                 // From operand fetch
    cdb_if.listener   cdb_i,                   // Wakeup source
    exec_if.source    exec_o                   // To this lane's ALU
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef enum logic [1:0] {
        FREE,                                  // Empty
        WAIT,                                  // Missing at least one operand
        READY                                  // Both operands present
    } rs_state_t;

    // ======================================================================
    // Entry storage
    // ======================================================================

    rs_state_t state    [RS_DEPTH];
    alu_op_t   op_q     [RS_DEPTH];
    word_t     a_val_q  [RS_DEPTH];
    word_t     b_val_q  [RS_DEPTH];
    logic      a_rdy_q  [RS_DEPTH];
    logic      b_rdy_q  [RS_DEPTH];
    slot_idx_t a_tag_q  [RS_DEPTH];
    slot_idx_t b_tag_q  [RS_DEPTH];
    slot_idx_t dest_q   [RS_DEPTH];

    // Select results
    logic                free_found;
    logic [RS_IDX_W-1:0] free_idx;
    logic                iss_found;
    logic [RS_IDX_W-1:0] iss_idx;
    logic                accept;

    // Per entry CDB match
    logic [RS_DEPTH-1:0] a_hit;
    logic [RS_DEPTH-1:0] b_hit;
    word_t               a_cdb [RS_DEPTH];
    word_t               b_cdb [RS_DEPTH];

    // Lowest free and lowest ready entry, walked from the top down
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        iss_found  = 1'b0;
        iss_idx    = '0;
        for (int e = RS_DEPTH - 1; e >= 0; e--) begin
            if (state[e] == FREE) begin
                free_found = 1'b1;
                free_idx   = RS_IDX_W'(e);
            end
            if (state[e] == READY) begin
                iss_found = 1'b1;
                iss_idx   = RS_IDX_W'(e);
            end
        end
    end

    assign entry_i.ready = free_found;     // Not full
    assign accept        = entry_i.valid & free_found;

    // Tag compare against all CDB lanes
    always_comb begin
        for (int e = 0; e < RS_DEPTH; e++) begin
            a_hit[e] = 1'b0;
            b_hit[e] = 1'b0;
            a_cdb[e] = '0;
            b_cdb[e] = '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (cdb_i.valid[l] && (cdb_i.slot[l] == a_tag_q[e])) begin
                    a_hit[e] = 1'b1;
                    a_cdb[e] = cdb_i.data[l];
                end
                if (cdb_i.valid[l] && (cdb_i.slot[l] == b_tag_q[e])) begin
                    b_hit[e] = 1'b1;
                    b_cdb[e] = cdb_i.data[l];
                end
            end
        end
    end

    // ======================================================================
    // Issue, combinational from the selected entry
    // ======================================================================

    assign exec_o.valid = iss_found;
    assign exec_o.op    = op_q[iss_idx];
    assign exec_o.a     = a_val_q[iss_idx];
    assign exec_o.b     = b_val_q[iss_idx];
    assign exec_o.dest  = dest_q[iss_idx];

    // Entry state
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int e = 0; e < RS_DEPTH; e++) begin
                state[e] <= FREE;
            end
        end else begin
            for (int e = 0; e < RS_DEPTH; e++) begin
                if (iss_found && (iss_idx == RS_IDX_W'(e))) begin
                    state[e] <= FREE;          // Leaves at the issue edge
                end else if ((state[e] == WAIT) && (a_rdy_q[e] || a_hit[e])
                             && (b_rdy_q[e] || b_hit[e])) begin
                    state[e] <= READY;         // Issues one cycle after wakeup
                end
            end
            if (accept) begin
                state[free_idx] <= (entry_i.a_rdy && entry_i.b_rdy) ? READY : WAIT;
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        for (int e = 0; e < RS_DEPTH; e++) begin
            if ((state[e] == WAIT) && !a_rdy_q[e] && a_hit[e]) begin
                a_val_q[e] <= a_cdb[e];
                a_rdy_q[e] <= 1'b1;
            end
            if ((state[e] == WAIT) && !b_rdy_q[e] && b_hit[e]) begin
                b_val_q[e] <= b_cdb[e];
                b_rdy_q[e] <= 1'b1;
            end
        end
        if (accept) begin                      // Only ever a FREE entry
            op_q[free_idx]    <= entry_i.op;
            a_val_q[free_idx] <= entry_i.a_val;
            a_rdy_q[free_idx] <= entry_i.a_rdy;
            a_tag_q[free_idx] <= entry_i.a_tag;
            b_val_q[free_idx] <= entry_i.b_val;
            b_rdy_q[free_idx] <= entry_i.b_rdy;
            b_tag_q[free_idx] <= entry_i.b_tag;
            dest_q[free_idx]  <= entry_i.dest;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dispatch_stage -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^Finished with no errors$" sim.log

/* tb.f */
core_pkg.sv
isa_pkg.sv
dispatch_ifs.sv
operand_fetch.sv
reservation_station.sv
alu_cluster.sv
dispatch_stage.sv
dispatch_stage_chk.sv
tb_dispatch_stage.sv

/* tb_dispatch_stage.sv */
module tb_dispatch_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int          PERIOD    = 4;
    localparam logic [31:0] SEED      = 32'h00a3365c;
    localparam int          N_INDEP   = 30;                   // Rounds of three lanes
    localparam int          N_CHAIN   = 24;
    localparam int          N_TOTAL   = N_INDEP * NUM_LANES + N_CHAIN + 30;
    localparam int          WDOG_CYC  = N_TOTAL * 40 + 500;   // 40 cycles each plus margin
    localparam int          DRAIN_CYC = 200;

    typedef struct packed {
        alu_op_t   op;
        src_addr_t src_a;
        src_addr_t src_b;
        logic      use_imm;
        word_t     imm;
        slot_idx_t dest;
    } instr_t;

    logic                          clk            = 1'b0;
    logic                          reset_i        = 1'b1;
    logic      [NUM_LANES-1:0]     disp_valid_i   = '0;
    logic      [NUM_LANES-1:0]     disp_ready_o;
    alu_op_t   [NUM_LANES-1:0]     disp_op_i      = '0;
    src_addr_t [NUM_LANES-1:0]     disp_src_a_i   = '0;
    src_addr_t [NUM_LANES-1:0]     disp_src_b_i   = '0;
    logic      [NUM_LANES-1:0]     disp_use_imm_i = '0;
    word_t     [NUM_LANES-1:0]     disp_imm_i     = '0;
    slot_idx_t [NUM_LANES-1:0]     disp_dest_i    = '0;
    logic                          retire_valid_i = 1'b0;
    reg_idx_t                      retire_reg_i   = '0;
    slot_idx_t                     retire_slot_i  = '0;
    logic      [NUM_LANES-1:0]     cdb_valid_o;
    slot_idx_t [NUM_LANES-1:0]     cdb_slot_o;
    word_t     [NUM_LANES-1:0]     cdb_data_o;

    // ======================================================================
    // Model state
    // ======================================================================

    word_t     reg_model  [ARCH_REGS];        // Registers as the caller sees them
    word_t     slot_model [NUM_SLOTS];        // Expected value of each finished slot
    instr_t    slot_instr [NUM_SLOTS];        // Last instruction aimed at the slot
    word_t     a_res      [NUM_SLOTS];        // Register operands resolved at send
    word_t     b_res      [NUM_SLOTS];
    logic      lat_chk    [NUM_SLOTS];        // No slot sources, so fixed latency
    longint    acc_t      [NUM_SLOTS];        // Accept edge time
    int        issued_cnt [NUM_SLOTS];
    int        done_cnt   [NUM_SLOTS];
    instr_t    lane_q     [NUM_LANES][$];     // Waiting to be driven
    logic      [NUM_LANES-1:0] acc_mask;
    int        n_sent     = 0;
    int        n_done     = 0;
    int        val_errs   = 0;
    int        proto_errs = 0;
    slot_idx_t next_slot  = '0;

    dispatch_stage uut (.*);

    initial begin
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Expected ALU result straight from the ISA rules
    function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b);
        word_t r;
        case (op)
            ADD: r = a + b;
            SUB: r = a - b;
            AND: r = a & b;
            OR:  r = a | b;
            XOR: r = a ^ b;
            SLL: r = a << b[4:0];
            SRL: r = a >> b[4:0];
            SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: r = 'x;
        endcase
        return r;
    endfunction

    function automatic src_addr_t reg_src(reg_idx_t r);
        return {1'b0, r};
    endfunction

    function automatic src_addr_t slot_src(slot_idx_t s);
        return {1'b1, s};
    endfunction

    function automatic alu_op_t rand_op();
        return alu_op_t'($urandom_range(0, 7));
    endfunction

    // Next slot with nothing in flight, waits a cycle when all are busy
    task automatic alloc_slot(output slot_idx_t s);
        int tries;
        tries = 0;
        while (issued_cnt[next_slot] != done_cnt[next_slot]) begin
            next_slot = next_slot + 1'b1;
            tries++;
            if (tries == NUM_SLOTS) begin
                @(negedge clk);                 // Let results come back
                tries = 0;
            end
        end
        s = next_slot;
        next_slot = next_slot + 1'b1;
    endtask

    // Queue one instruction and note what the model expects
    task automatic push(int lane, alu_op_t op, src_addr_t sa, src_addr_t sb,
                        logic use_imm, word_t imm, slot_idx_t dest);
        instr_t i;
        i = '{op: op, src_a: sa, src_b: sb, use_imm: use_imm, imm: imm, dest: dest};
        slot_instr[dest] = i;
        a_res[dest]   = sa[SRC_W-1] ? '0 : reg_model[sa[REG_W-1:0]];
        b_res[dest]   = use_imm ? imm : (sb[SRC_W-1] ? '0 : reg_model[sb[REG_W-1:0]]);
        lat_chk[dest] = !sa[SRC_W-1] && (use_imm || !sb[SRC_W-1]);
        issued_cnt[dest]++;
        n_sent++;
        lane_q[lane].push_back(i);
    endtask

    task automatic retire_slot(reg_idx_t r, slot_idx_t s);
        @(posedge clk);
        retire_valid_i <= 1'b1;
        retire_reg_i   <= r;
        retire_slot_i  <= s;
        @(posedge clk);
        retire_valid_i <= 1'b0;
        if (r != '0) reg_model[r] = slot_model[s];   // r0 stays zero
    endtask

    // Wait until every sent instruction has strobed
    task automatic drain();
        int waited;
        waited = 0;
        while ((n_sent != n_done) && (waited < DRAIN_CYC)) begin
            @(posedge clk);
            waited++;
        end
        if (n_sent != n_done) begin
            proto_errs++;
            $display("A dispatch was never answered by a result strobe: %0d outstanding",
                     n_sent - n_done);
        end
    endtask

    // ======================================================================
    // Dispatch driver, one queue per lane
    // ======================================================================

    always @(negedge clk) acc_mask <= disp_valid_i & disp_ready_o;   // Stable mid cycle

    always @(posedge clk) begin
        if (reset_i) begin
            disp_valid_i <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (acc_mask[l] && (lane_q[l].size() > 0)) begin
                    acc_t[lane_q[l][0].dest] = $time;   // This edge is the accept
                    void'(lane_q[l].pop_front());
                end
                if (lane_q[l].size() > 0) begin
                    disp_valid_i[l]   <= 1'b1;
                    disp_op_i[l]      <= lane_q[l][0].op;
                    disp_src_a_i[l]   <= lane_q[l][0].src_a;
                    disp_src_b_i[l]   <= lane_q[l][0].src_b;
                    disp_use_imm_i[l] <= lane_q[l][0].use_imm;
                    disp_imm_i[l]     <= lane_q[l][0].imm;
                    disp_dest_i[l]    <= lane_q[l][0].dest;
                end else begin
                    disp_valid_i[l] <= 1'b0;
                end
            end
        end
    end

    // ======================================================================
    // Compare every CDB strobe with the model
    // ======================================================================

    always @(negedge clk) begin : compare
        slot_idx_t s;
        instr_t    i;
        word_t     a;
        word_t     b;
        word_t     exp;
        if (!reset_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (cdb_valid_o[l]) begin
                    s = cdb_slot_o[l];
                    if (issued_cnt[s] == done_cnt[s]) begin
                        proto_errs++;
                        $display("Result strobe on lane %0d for slot %0d, which is not in flight",
                                 l, s);
                    end else begin
                        i = slot_instr[s];
                        a = i.src_a[SRC_W-1] ? slot_model[i.src_a[SLOT_W-1:0]] : a_res[s];
                        b = (!i.use_imm && i.src_b[SRC_W-1]) ?
                            slot_model[i.src_b[SLOT_W-1:0]] : b_res[s];
                        exp = ref_alu(i.op, a, b);
                        if (cdb_data_o[l] !== exp) begin
                            val_errs++;
                            $display("error at %0d ns: slot %0d got %h, expected %h",
                                     $time, s, cdb_data_o[l], exp);
                        end
                        // Strobe cycle sits between accept edge +1 and +2
                        if (lat_chk[s] && ($time != acc_t[s] + PERIOD + PERIOD / 2)) begin
                            val_errs++;
                            $display("error at %0d ns: slot %0d strobed with wrong latency",
                                     $time, s);
                        end
                        slot_model[s] = exp;
                        done_cnt[s]++;
                        n_done++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WDOG_CYC);
        $display("Finished with errors");
        $finish;
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        slot_idx_t p;
        slot_idx_t c;
        slot_idx_t prev;
        slot_idx_t prev2;
        void'($urandom(SEED));
        for (int r = 0; r < ARCH_REGS; r++) reg_model[r] = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            issued_cnt[s] = 0;
            done_cnt[s]   = 0;
        end
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        // Back-pressure, five on lane 0 waiting on never produced slot 31
        @(negedge clk);
        for (int k = 0; k < 5; k++) begin
            alloc_slot(c);
            push(0, rand_op(), slot_src(5'd31), reg_src('0), 1'b1, $urandom, c);
        end
        repeat (10) @(negedge clk);
        if ((disp_ready_o[0] !== 1'b0) || (lane_q[0].size() != 1)) begin
            proto_errs++;
            $display("Lane 0 did not hold back its fifth instruction while the station was full");
        end
        push(1, ADD, reg_src('0), reg_src('0), 1'b1, $urandom, 5'd31);
        drain();

        // Dependence chains across lanes
        @(negedge clk);
        alloc_slot(prev2);
        push(0, rand_op(), reg_src('0), reg_src('0), 1'b1, $urandom, prev2);
        alloc_slot(prev);
        push(1, rand_op(), reg_src('0), reg_src('0), 1'b1, $urandom, prev);
        for (int k = 0; k < N_CHAIN; k++) begin
            @(negedge clk);
            alloc_slot(c);
            push(k % NUM_LANES, rand_op(), slot_src(prev), slot_src(prev2),
                 1'($urandom_range(0, 1)), $urandom, c);
            prev2 = prev;
            prev  = c;
        end
        drain();

        // Consumer dispatched in the producer's strobe cycle
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            alloc_slot(p);
            push(0, rand_op(), reg_src('0), reg_src('0), 1'b1, $urandom, p);
            @(negedge clk);
            @(negedge clk);
            alloc_slot(c);
            push(1, rand_op(), slot_src(p), reg_src('0), 1'b1, $urandom, c);
            drain();
        end

        // Retire, then read back, r0 stays zero
        retire_slot(5'd7, c);
        retire_slot(5'd3, p);
        retire_slot(5'd0, c);
        @(negedge clk);
        alloc_slot(c);
        push(2, rand_op(), reg_src(5'd7), reg_src(5'd3), 1'b0, '0, c);
        alloc_slot(c);
        push(0, OR, reg_src(5'd0), reg_src(5'd0), 1'b0, '0, c);
        drain();

        // Independent instructions from registers and immediates
        for (int k = 0; k < N_INDEP; k++) begin
            @(negedge clk);
            for (int l = 0; l < NUM_LANES; l++) begin
                alloc_slot(c);
                push(l, rand_op(), reg_src(5'($urandom_range(0, 31))),
                     reg_src(5'($urandom_range(0, 31))), 1'($urandom_range(0, 1)),
                     $urandom, c);
            end
        end
        drain();

        repeat (5) @(posedge clk);
        $display("Error counts: value %0d, protocol %0d, assertion %0d",
                 val_errs, proto_errs, uut.u_chk.assert_errs);
        if ((val_errs == 0) && (proto_errs == 0) && (uut.u_chk.assert_errs == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
